// ==== Bender.yml ====
package:
  name: kv_table

dependencies: {}

sources:
  # package first, then leaf modules, then the top level
  - files:
      - source/kv_pkg.sv
      - source/tick_timer.sv
      - source/entry_store.sv
      - source/lookup_fsm.sv
      - source/entry_judge.sv
      - source/kv_table.sv

  # testbench, top module tb_kv_table
  - target: test
    files:
      - verification/tb_kv_table.sv

// ==== source/entry_judge.sv ====
`timescale 1ns/10ps

module entry_judge (
	input  logic            clk156,
	input  logic            rst,
	input  logic            check,
	input  logic            rd_valid,
	input  kv_pkg::op_t     req_op,
	input  kv_pkg::key_t    req_key,
	input  kv_pkg::key_t    rd_key,
	input  kv_pkg::value_t  rd_value,
	input  kv_pkg::stamp_t  rd_stamp,
	input  kv_pkg::stamp_t  stamp,
	output logic            out_valid,
	output kv_pkg::flag_t   out_flag,
	output kv_pkg::value_t  out_value
);

	import kv_pkg::*;

	stamp_t age;
	logic   key_match;
	logic   expired;
	flag_t  next_flag;
	value_t next_value;

	// modulo difference, correct across stamp wrap
	assign age       = stamp - rd_stamp;
	assign key_match = rd_valid && (rd_key == req_key);
	assign expired   = (age >= EXPIRE_AGE);

	always_comb begin
		next_value = '0;
		if (req_op[1:0] == OP_SET[1:0]) begin
			next_flag = FLAG_STORED;
		end else if (req_op[1:0] == OP_DEL[1:0]) begin
			next_flag = FLAG_DELETED;
		end else if (key_match && !expired) begin
			next_flag  = FLAG_HIT;
			next_value = rd_value;
		end else if (key_match) begin
			next_flag = FLAG_EXPIRED;
		end else begin
			// empty slot or another key sits there
			next_flag = FLAG_MISS;
		end
	end

	always_ff @(posedge clk156) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= check;
		end
	end

	always_ff @(posedge clk156) begin
		if (check) begin
			out_flag  <= next_flag;
			out_value <= next_value;
		end
	end

	// one response pulse per request
	a_single_pulse: assert property (@(posedge clk156) disable iff (rst)
		out_valid |=> !out_valid);

endmodule

// ==== source/entry_store.sv ====
`timescale 1ns/10ps

module entry_store (
	input  logic                 clk156,
	input  logic                 rst,
	input  logic                 rd_en,
	input  logic                 wr_en,
	input  logic                 clr_en,
	input  kv_pkg::table_addr_t  rd_addr,
	input  kv_pkg::table_addr_t  wr_addr,
	input  kv_pkg::key_t         wr_key,
	input  kv_pkg::value_t       wr_value,
	input  kv_pkg::stamp_t       wr_stamp,
	output logic                 rd_valid,
	output kv_pkg::key_t         rd_key,
	output kv_pkg::value_t       rd_value,
	output kv_pkg::stamp_t       rd_stamp
);

	import kv_pkg::*;

	key_t   key_mem   [TABLE_DEPTH];
	value_t value_mem [TABLE_DEPTH];
	stamp_t stamp_mem [TABLE_DEPTH];

	logic [TABLE_DEPTH-1:0] valid_map;

	// entry payload, block RAM style
	always_ff @(posedge clk156) begin
		if (wr_en) begin
			key_mem[wr_addr]   <= wr_key;
			value_mem[wr_addr] <= wr_value;
			stamp_mem[wr_addr] <= wr_stamp;
		end
		if (rd_en) begin
			rd_key   <= key_mem[rd_addr];
			rd_value <= value_mem[rd_addr];
			rd_stamp <= stamp_mem[rd_addr];
		end
	end

	// occupancy bits, cleared on reset
	always_ff @(posedge clk156) begin
		if (rst) begin
			valid_map <= '0;
			rd_valid  <= 1'b0;
		end else begin
			if (wr_en) begin
				valid_map[wr_addr] <= 1'b1;
			end else if (clr_en) begin
				valid_map[wr_addr] <= 1'b0;
			end
			if (rd_en) begin
				rd_valid <= valid_map[rd_addr];
			end
		end
	end

	// lookup_fsm decodes one opcode per request
	a_wr_clr_exclusive: assert property (@(posedge clk156) disable iff (rst)
		!(wr_en && clr_en));

endmodule

// ==== source/kv_pkg.sv ====
package kv_pkg;

	// request fields
	typedef logic [31:0] hash_t;
	typedef logic [95:0] key_t;
	typedef logic [31:0] value_t;
	typedef logic [3:0]  op_t;
	typedef logic [3:0]  flag_t;

	// direct-mapped table, one way per slot
	localparam int TABLE_DEPTH = 1024;
	localparam int TABLE_AW    = $clog2(TABLE_DEPTH);

	typedef logic [TABLE_AW-1:0] table_addr_t;

	// entry age in timer ticks
	typedef logic [15:0] stamp_t;

	// opcodes, only bits [1:0] are decoded
	localparam op_t OP_GET = 4'd0;
	localparam op_t OP_SET = 4'd1;
	localparam op_t OP_DEL = 4'd2;

	// one-hot response codes, miss is all zero
	localparam flag_t FLAG_MISS    = 4'd0;
	localparam flag_t FLAG_HIT     = 4'd1;
	localparam flag_t FLAG_STORED  = 4'd2;
	localparam flag_t FLAG_DELETED = 4'd4;
	localparam flag_t FLAG_EXPIRED = 4'd8;

	// clk156 cycles per tick
	localparam int TICK_DIV    = 16;
	localparam int PRESCALE_W  = $clog2(TICK_DIV);

	// 64 ticks, roughly 1024 cycles
	localparam stamp_t EXPIRE_AGE = 16'd64;

	// read is issued on the strobe, check follows one cycle later
	typedef enum logic [0:0] {
		IDLE,
		CHECK
	} lookup_state_e;

endpackage

// ==== source/kv_table.sv ====
`timescale 1ns/10ps

module kv_table (
	input  logic            clk156,
	input  logic            rst,
	input  logic            in_valid,
	input  kv_pkg::op_t     in_op,
	input  kv_pkg::hash_t   in_hash,
	input  kv_pkg::key_t    in_key,
	input  kv_pkg::value_t  in_value,
	output logic            out_valid,
	output kv_pkg::flag_t   out_flag,
	output kv_pkg::value_t  out_value
);

	import kv_pkg::*;

	stamp_t      stamp;
	logic        rd_en;
	logic        wr_en;
	logic        clr_en;
	logic        check;
	op_t         req_op;
	table_addr_t req_addr;
	table_addr_t rd_addr;
	key_t        req_key;
	value_t      req_value;
	logic        rd_valid;
	key_t        rd_key;
	value_t      rd_value;
	stamp_t      rd_stamp;

	// slot index straight from the low hash bits
	assign rd_addr = in_hash[TABLE_AW-1:0];

	tick_timer timer_i (
		.clk156 (clk156),
		.rst    (rst),
		.stamp  (stamp)
	);

	lookup_fsm fsm_i (
		.clk156    (clk156),    .rst      (rst),
		.in_valid  (in_valid),  .in_op    (in_op),
		.in_hash   (in_hash),   .in_key   (in_key),
		.in_value  (in_value),  .rd_en    (rd_en),
		.wr_en     (wr_en),     .clr_en   (clr_en),
		.check     (check),     .req_op   (req_op),
		.req_addr  (req_addr),  .req_key  (req_key),
		.req_value (req_value)
	);

	// writes land at the latched slot during CHECK
	entry_store store_i (
		.clk156   (clk156),    .rst      (rst),
		.rd_en    (rd_en),     .wr_en    (wr_en),
		.clr_en   (clr_en),    .rd_addr  (rd_addr),
		.wr_addr  (req_addr),  .wr_key   (req_key),
		.wr_value (req_value), .wr_stamp (stamp),
		.rd_valid (rd_valid),  .rd_key   (rd_key),
		.rd_value (rd_value),  .rd_stamp (rd_stamp)
	);

	entry_judge judge_i (
		.clk156    (clk156),    .rst      (rst),
		.check     (check),     .rd_valid (rd_valid),
		.req_op    (req_op),    .req_key  (req_key),
		.rd_key    (rd_key),    .rd_value (rd_value),
		.rd_stamp  (rd_stamp),  .stamp    (stamp),
		.out_valid (out_valid), .out_flag (out_flag),
		.out_value (out_value)
	);

endmodule

// ==== source/lookup_fsm.sv ====
`timescale 1ns/10ps

module lookup_fsm (
	input  logic                 clk156,
	input  logic                 rst,
	input  logic                 in_valid,
	input  kv_pkg::op_t          in_op,
	input  kv_pkg::hash_t        in_hash,
	input  kv_pkg::key_t         in_key,
	input  kv_pkg::value_t       in_value,
	output logic                 rd_en,
	output logic                 wr_en,
	output logic                 clr_en,
	output logic                 check,
	output kv_pkg::op_t          req_op,
	output kv_pkg::table_addr_t  req_addr,
	output kv_pkg::key_t         req_key,
	output kv_pkg::value_t       req_value
);

	import kv_pkg::*;

	lookup_state_e state;
	logic          accept;

	// a strobe during CHECK is dropped
	assign accept = in_valid && (state == IDLE);

	always_ff @(posedge clk156) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:    state <= accept ? CHECK : IDLE;
				CHECK:   state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// request latch
	always_ff @(posedge clk156) begin
		if (accept) begin
			req_op    <= in_op;
			req_addr  <= in_hash[TABLE_AW-1:0];
			req_key   <= in_key;
			req_value <= in_value;
		end
	end

	// store reads the slot at the strobe edge
	assign rd_en  = accept;
	assign check  = (state == CHECK);
	assign wr_en  = check && (req_op[1:0] == OP_SET[1:0]);
	assign clr_en = check && (req_op[1:0] == OP_DEL[1:0]);

	// sender leaves one idle cycle after each request
	a_min_spacing: assert property (@(posedge clk156) disable iff (rst)
		accept |=> !in_valid);

endmodule

// ==== source/tick_timer.sv ====
`timescale 1ns/10ps

module tick_timer (
	input  logic            clk156,
	input  logic            rst,
	output kv_pkg::stamp_t  stamp
);

	import kv_pkg::*;

	logic [PRESCALE_W-1:0] pre_cnt;
	logic                  tick;

	// one-cycle enable every TICK_DIV cycles
	assign tick = (pre_cnt == PRESCALE_W'(TICK_DIV - 1));

	always_ff @(posedge clk156) begin
		if (rst) begin
			pre_cnt <= '0;
		end else if (tick) begin
			pre_cnt <= '0;
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
		end
	end

	// free running, wraps at 16 bits
	always_ff @(posedge clk156) begin
		if (rst) begin
			stamp <= '0;
		end else if (tick) begin
			stamp <= stamp + 1'b1;
		end
	end

endmodule

// ==== verification/tb_kv_table.sv ====
`timescale 1ns/10ps

module tb_kv_table;

	import kv_pkg::*;

	localparam int CLK_PERIOD    = 10;
	localparam int N_RAND        = 8;
	localparam int N_MIX         = 40;
	localparam int EXPIRE_WAIT   = 1500;
	// 64 ticks of 16 cycles
	localparam int EXPIRE_CYCLES = 1024;
	localparam int AGE_GUARD_LO  = 900;
	localparam int AGE_GUARD_HI  = 1200;
	// reset, six tests at two cycles per request, expiry wait, drain
	localparam int TEST_CYCLES   = 4 + 2 * N_RAND + 4 * N_RAND + 8 + 6
		+ (EXPIRE_WAIT + 8) + 2 * N_MIX + 4;
	localparam int WATCHDOG_NS   = TEST_CYCLES * CLK_PERIOD * 12 / 10;

	logic   clk156;
	logic   rst;
	logic   in_valid;
	op_t    in_op;
	hash_t  in_hash;
	key_t   in_key;
	value_t in_value;
	logic   out_valid;
	flag_t  out_flag;
	value_t out_value;

	int errors = 0;
	int checks = 0;
	int cycle  = 0;

	// reference model, one entry per slot
	key_t   model_key   [int];
	value_t model_value [int];
	int     model_cycle [int];

	// expected responses in request order
	string  exp_name_q  [$];
	flag_t  exp_flag_q  [$];
	value_t exp_value_q [$];

	kv_table dut_i (
		.clk156    (clk156),    .rst       (rst),
		.in_valid  (in_valid),  .in_op     (in_op),
		.in_hash   (in_hash),   .in_key    (in_key),
		.in_value  (in_value),  .out_valid (out_valid),
		.out_flag  (out_flag),  .out_value (out_value)
	);

	initial clk156 = 1'b0;
	always #(CLK_PERIOD / 2) clk156 = ~clk156;

	always @(posedge clk156) begin
		cycle <= cycle + 1;
	end

	a_resp_latency: assert property (@(posedge clk156) disable iff (rst)
		in_valid |-> ##2 out_valid)
		else begin
			errors++;
			$display("no response two edges after a request");
		end

	a_resp_origin: assert property (@(posedge clk156) disable iff (rst)
		out_valid |-> $past(in_valid, 2))
		else begin
			errors++;
			$display("response without a request two edges earlier");
		end

	// outputs are stable between edges
	always @(negedge clk156) begin : response_check
		string  name;
		flag_t  e_flag;
		value_t e_value;
		if (!rst && out_valid) begin
			if (exp_flag_q.size() == 0) begin
				errors++;
				$display("response arrived with no request outstanding");
			end else begin
				name    = exp_name_q.pop_front();
				e_flag  = exp_flag_q.pop_front();
				e_value = exp_value_q.pop_front();
				checks++;
				assert (out_flag == e_flag)
					else begin
						errors++;
						$display("[FAIL] %s: flag expected %h, actual %h", name, e_flag, out_flag);
					end
				assert (out_value == e_value)
					else begin
						errors++;
						$display("[FAIL] %s: value expected %h, actual %h", name, e_value,
							out_value);
					end
			end
		end
	end

	function automatic key_t random_key();
		return {$urandom, $urandom, $urandom};
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk156);
	endtask

	// one strobe, then one idle cycle
	task automatic send_request(input string name, input op_t op, input hash_t hash,
			input key_t key, input value_t value);
		int     slot;
		int     age;
		flag_t  e_flag;
		value_t e_value;
		@(negedge clk156);
		slot    = int'(hash[9:0]);
		e_flag  = FLAG_MISS;
		e_value = '0;
		case (op)
			OP_SET: begin
				e_flag            = FLAG_STORED;
				model_key[slot]   = key;
				model_value[slot] = value;
				model_cycle[slot] = cycle;
			end
			OP_DEL: begin
				e_flag = FLAG_DELETED;
				model_key.delete(slot);
				model_value.delete(slot);
				model_cycle.delete(slot);
			end
			default: begin
				if (model_key.exists(slot) && model_key[slot] == key) begin
					age = cycle - model_cycle[slot];
					if (age >= AGE_GUARD_LO && age <= AGE_GUARD_HI) begin
						errors++;
						$display("%s: lookup issued too close to the expiry age", name);
					end
					if (age >= EXPIRE_CYCLES) begin
						e_flag = FLAG_EXPIRED;
					end else begin
						e_flag  = FLAG_HIT;
						e_value = model_value[slot];
					end
				end
			end
		endcase
		exp_name_q.push_back(name);
		exp_flag_q.push_back(e_flag);
		exp_value_q.push_back(e_value);
		in_valid = 1'b1;
		in_op    = op;
		in_hash  = hash;
		in_key   = key;
		in_value = value;
		@(negedge clk156);
		in_valid = 1'b0;
	endtask

	task automatic get_after_reset();
		repeat (N_RAND) send_request("get_after_reset", OP_GET, $urandom, random_key(), '0);
	endtask

	task automatic set_then_get();
		hash_t hashes [N_RAND];
		key_t  keys   [N_RAND];
		for (int i = 0; i < N_RAND; i++) begin
			hashes[i] = $urandom;
			keys[i]   = random_key();
			send_request("set_then_get", OP_SET, hashes[i], keys[i], $urandom);
		end
		for (int i = 0; i < N_RAND; i++) begin
			send_request("set_then_get", OP_GET, hashes[i], keys[i], '0);
		end
	endtask

	// same slot, different upper hash bits
	task automatic slot_collision();
		hash_t hash_a;
		hash_t hash_b;
		key_t  key_a;
		key_t  key_b;
		hash_a = $urandom;
		hash_b = {~hash_a[31:10], hash_a[9:0]};
		key_a  = random_key();
		key_b  = random_key();
		send_request("slot_collision", OP_SET, hash_a, key_a, $urandom);
		send_request("slot_collision", OP_SET, hash_b, key_b, $urandom);
		send_request("slot_collision", OP_GET, hash_a, key_a, '0);
		send_request("slot_collision", OP_GET, hash_b, key_b, '0);
	endtask

	task automatic delete_entry();
		hash_t hash;
		key_t  key;
		hash = $urandom;
		key  = random_key();
		send_request("delete_entry", OP_SET, hash, key, $urandom);
		send_request("delete_entry", OP_DEL, hash, key, '0);
		send_request("delete_entry", OP_GET, hash, key, '0);
	endtask

	task automatic entry_expiry();
		hash_t hash;
		key_t  key;
		hash = $urandom;
		key  = random_key();
		send_request("entry_expiry", OP_SET, hash, key, $urandom);
		idle_cycles(EXPIRE_WAIT);
		send_request("entry_expiry", OP_GET, hash, key, '0);
		send_request("entry_expiry", OP_SET, hash, key, $urandom);
		send_request("entry_expiry", OP_GET, hash, key, '0);
	endtask

	// small key pool so lookups actually hit
	task automatic mixed_traffic();
		hash_t pool_hash [4];
		key_t  pool_key  [4];
		int    idx;
		for (int i = 0; i < 4; i++) begin
			pool_hash[i] = $urandom;
			pool_key[i]  = random_key();
		end
		for (int i = 0; i < N_MIX; i++) begin
			idx = $urandom_range(3, 0);
			send_request("mixed_traffic", op_t'($urandom_range(2, 0)), pool_hash[idx],
				pool_key[idx], $urandom);
		end
	endtask

	initial begin
		void'($urandom(32'h2751_2233));
		rst      = 1'b1;
		in_valid = 1'b0;
		in_op    = '0;
		in_hash  = '0;
		in_key   = '0;
		in_value = '0;
		repeat (2) @(posedge clk156);
		@(negedge clk156);
		rst = 1'b0;
		get_after_reset();
		set_then_get();
		slot_collision();
		delete_entry();
		entry_expiry();
		mixed_traffic();
		idle_cycles(4);
		if (exp_flag_q.size() != 0) begin
			errors++;
			$display("%0d requests never got a response", exp_flag_q.size());
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
source/kv_pkg.sv
source/tick_timer.sv
source/entry_store.sv
source/lookup_fsm.sv
source/entry_judge.sv
source/kv_table.sv
verification/tb_kv_table.sv
